/* accPkg.sv */
`default_nettype none

package accPkg;

    // data path and instruction word width
    // ALU codes and instruction fields are laid out for 16 bits
    localparam int wordWidth = 16;

    // instruction class in bits 15 to 12
    typedef enum logic [3:0] {
        opNop,
        opLoad,
        opStore,
        opAlu,
        opJump,
        opJumpZero,
        opHalt
    } instrOpT;

    // ALU operation in bits 11 to 8
    // only read by opAlu
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluMul,
        aluDiv,
        aluShl,
        aluShr,
        aluRol,
        aluRor,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluNand,
        aluXnor,
        aluGreater,
        aluEqual
    } aluOpT;

    // core sequencer states
    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stFetchWait,
        stDecode,
        stOperand,
        stOperandWait,
        stExecute
    } seqStateT;

endpackage

`default_nettype wire

/* memBus.sv */
`timescale 1ns/10ps
`default_nettype none

// one requester's path to main memory
// sel and fields are held until grant is seen high
interface memBus #(
    parameter int addrWidth = 8
);
    import accPkg::*;

    logic                 sel;
    logic                 write;
    logic [addrWidth-1:0] addr;
    logic [wordWidth-1:0] wdata;
    // read data is valid the cycle after a granted read
    logic [wordWidth-1:0] rdata;
    logic                 grant;

    modport master (
        output sel, write, addr, wdata,
        input  rdata, grant
    );

    modport arbiter (
        input  sel, write, addr, wdata,
        output rdata, grant
    );

endinterface

`default_nettype wire

/* mainMemory.sv */
`timescale 1ns/10ps
`default_nettype none

// shared program and data store
// word addressed with one cycle read latency
module mainMemory #(
    parameter int addrWidth = 8
) (
    input  logic                         clock,
    input  logic [addrWidth-1:0]         addr,
    input  logic [accPkg::wordWidth-1:0] wdata,
    input  logic                         write,
    output logic [accPkg::wordWidth-1:0] rdata
);
    import accPkg::*;

    // full address space of words
    logic [wordWidth-1:0] memArray [2**addrWidth];

    always_ff @(posedge clock) begin
        if (write) begin
            memArray[addr] <= wdata;
        end else begin
            // output only updates on read cycles
            rdata <= memArray[addr];
        end
    end

endmodule

`default_nettype wire

/* aluUnit.sv */
`timescale 1ns/10ps
`default_nettype none

// sixteen-operation combinational ALU
module aluUnit (
    input  accPkg::aluOpT                opcode,
    input  logic [accPkg::wordWidth-1:0] operandA,
    input  logic [accPkg::wordWidth-1:0] operandB,
    output logic [accPkg::wordWidth-1:0] result
);
    import accPkg::*;

    always_comb begin
        case (opcode)
            aluAdd:     result = operandA + operandB;
            aluSub:     result = operandA - operandB;
            // low half of the product only
            aluMul:     result = operandA * operandB;
            // divide by zero saturates to all ones
            aluDiv:     result = (operandB == '0) ? '1 : operandA / operandB;
            // single-bit shifts and rotates of A
            aluShl:     result = operandA << 1;
            aluShr:     result = operandA >> 1;
            aluRol:     result = {operandA[wordWidth-2:0], operandA[wordWidth-1]};
            aluRor:     result = {operandA[0], operandA[wordWidth-1:1]};
            // bitwise group
            aluAnd:     result = operandA & operandB;
            aluOr:      result = operandA | operandB;
            aluXor:     result = operandA ^ operandB;
            aluNor:     result = ~(operandA | operandB);
            aluNand:    result = ~(operandA & operandB);
            aluXnor:    result = ~(operandA ^ operandB);
            // compares give 1 or 0 in the low bit
            aluGreater: result = {{(wordWidth-1){1'b0}}, operandA > operandB};
            aluEqual:   result = {{(wordWidth-1){1'b0}}, operandA == operandB};
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* memArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

// host-first arbiter onto the single memory port
module memArbiter #(
    parameter int addrWidth = 8
) (
    input  logic                         clock,
    memBus.arbiter                       hostBus,
    memBus.arbiter                       coreBus,
    output logic [addrWidth-1:0]         memAddr,
    output logic                         memWrite,
    output logic [accPkg::wordWidth-1:0] memWdata,
    input  logic [accPkg::wordWidth-1:0] memRdata
);

    // which side owns the data now on memRdata
    logic hostReadQ;
    logic coreReadQ;

    // host always wins
    assign hostBus.grant = hostBus.sel;
    // core only when host is quiet
    assign coreBus.grant = coreBus.sel && !hostBus.sel;

    // winner's request onto the memory
    assign memAddr  = hostBus.sel ? hostBus.addr : coreBus.addr;
    assign memWdata = hostBus.sel ? hostBus.wdata : coreBus.wdata;
    assign memWrite = hostBus.sel ? hostBus.write : (coreBus.grant && coreBus.write);

    // tag the read issued this cycle
    always_ff @(posedge clock) begin
        hostReadQ <= hostBus.grant && !hostBus.write;
        coreReadQ <= coreBus.grant && !coreBus.write;
    end

    // memory output reaches only the side that read it
    // the other side sees zero
    assign hostBus.rdata = hostReadQ ? memRdata : '0;
    assign coreBus.rdata = coreReadQ ? memRdata : '0;

endmodule

`default_nettype wire

/* accCore.sv */
`timescale 1ns/10ps
`default_nettype none

// accumulator processor
// fetch, decode, then operand access for memory-class instructions
module accCore #(
    parameter int addrWidth = 8
) (
    input  logic                         clock,
    input  logic                         rstN,
    input  logic                         start,
    input  logic [accPkg::wordWidth-1:0] aluResult,
    memBus.master                        mem,
    output accPkg::aluOpT                aluOp,
    output logic [accPkg::wordWidth-1:0] aluA,
    output logic [accPkg::wordWidth-1:0] aluB,
    output logic                         busy
);
    import accPkg::*;

    // architectural registers
    logic [wordWidth-1:0] acc;
    logic [addrWidth-1:0] pc;
    logic [wordWidth-1:0] ir;
    // address and buffer registers facing memory
    logic [addrWidth-1:0] mar;
    logic [wordWidth-1:0] mbr;
    seqStateT             state;

    // instruction fields
    instrOpT              irOp;
    logic [addrWidth-1:0] irAddr;

    assign irOp   = instrOpT'(ir[15:12]);
    // address field is 8 bits and addrWidth never exceeds it
    assign irAddr = ir[addrWidth-1:0];

    // ALU always sees acc against the buffered operand
    assign aluOp = aluOpT'(ir[11:8]);
    assign aluA  = acc;
    assign aluB  = mbr;

    assign busy = (state != stIdle);

    // request only in the two access states
    assign mem.sel   = (state == stFetch) || (state == stOperand);
    assign mem.write = (state == stOperand) && (irOp == opStore);
    assign mem.addr  = mar;
    assign mem.wdata = mbr;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= stIdle;
            acc   <= '0;
            pc    <= '0;
            ir    <= '0;
            mar   <= '0;
            mbr   <= '0;
        end else begin
            case (state)
                stIdle: begin
                    // program always starts at word zero
                    if (start) begin
                        pc    <= '0;
                        mar   <= '0;
                        state <= stFetch;
                    end
                end
                stFetch: begin
                    // wait here while the host holds memory
                    if (mem.grant) begin
                        pc    <= pc + addrWidth'(1);
                        state <= stFetchWait;
                    end
                end
                stFetchWait: begin
                    ir    <= mem.rdata;
                    state <= stDecode;
                end
                stDecode: begin
                    // next fetch from pc unless redirected below
                    mar   <= pc;
                    state <= stFetch;
                    case (irOp)
                        opLoad, opAlu: begin
                            mar   <= irAddr;
                            state <= stOperand;
                        end
                        opStore: begin
                            mar   <= irAddr;
                            mbr   <= acc;
                            state <= stOperand;
                        end
                        opJump: begin
                            pc  <= irAddr;
                            mar <= irAddr;
                        end
                        opJumpZero: begin
                            // zero test straight off the accumulator
                            if (acc == '0) begin
                                pc  <= irAddr;
                                mar <= irAddr;
                            end
                        end
                        opHalt: begin
                            state <= stIdle;
                        end
                        // nop and unused codes just move on
                        default: begin
                        end
                    endcase
                end
                stOperand: begin
                    // store data is written at this grant edge
                    if (mem.grant) begin
                        state <= stOperandWait;
                    end
                end
                stOperandWait: begin
                    if (irOp != opStore) begin
                        mbr <= mem.rdata;
                    end
                    state <= stExecute;
                end
                stExecute: begin
                    if (irOp == opLoad) begin
                        acc <= mbr;
                    end else if (irOp == opAlu) begin
                        acc <= aluResult;
                    end
                    mar   <= pc;
                    state <= stFetch;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* accComputer.sv */
`timescale 1ns/10ps
`default_nettype none

// accumulator computer with a host port sharing main memory
module accComputer #(
    parameter int addrWidth = 8
) (
    input  logic                         clock,
    input  logic                         rstN,
    input  logic                         start,
    input  logic                         hostSel,
    input  logic                         hostWrite,
    input  logic [addrWidth-1:0]         hostAddr,
    input  logic [accPkg::wordWidth-1:0] hostWdata,
    output logic [accPkg::wordWidth-1:0] hostRdata,
    output logic                         busy
);
    import accPkg::*;

    // arbitrated memory port
    logic [addrWidth-1:0] memAddr;
    logic                 memWrite;
    logic [wordWidth-1:0] memWdata;
    logic [wordWidth-1:0] memRdata;

    // core to ALU
    aluOpT                aluOp;
    logic [wordWidth-1:0] aluA;
    logic [wordWidth-1:0] aluB;
    logic [wordWidth-1:0] aluResult;

    memBus #(.addrWidth(addrWidth)) hostBus ();
    memBus #(.addrWidth(addrWidth)) coreBus ();

    // host pins onto their bus
    assign hostBus.sel   = hostSel;
    assign hostBus.write = hostWrite;
    assign hostBus.addr  = hostAddr;
    assign hostBus.wdata = hostWdata;
    assign hostRdata     = hostBus.rdata;

    accCore #(.addrWidth(addrWidth)) i_core (
        .clock(clock), .rstN(rstN), .start(start), .aluResult(aluResult),
        .mem(coreBus), .aluOp(aluOp), .aluA(aluA), .aluB(aluB), .busy(busy)
    );

    memArbiter #(.addrWidth(addrWidth)) i_arbiter (
        .clock(clock), .hostBus(hostBus), .coreBus(coreBus),
        .memAddr(memAddr), .memWrite(memWrite), .memWdata(memWdata),
        .memRdata(memRdata)
    );

    mainMemory #(.addrWidth(addrWidth)) i_memory (
        .clock(clock), .addr(memAddr), .wdata(memWdata),
        .write(memWrite), .rdata(memRdata)
    );

    aluUnit i_alu (
        .opcode(aluOp), .operandA(aluA), .operandB(aluB), .result(aluResult)
    );

endmodule

`default_nettype wire

/* accChecker.sv */
`timescale 1ns/10ps
`default_nettype none

// watches the host port and judges every host read
module accChecker #(
    parameter int addrWidth = 8
) (
    input logic                         clock,
    input logic                         hostSel,
    input logic                         hostWrite,
    input logic [addrWidth-1:0]         hostAddr,
    input logic [accPkg::wordWidth-1:0] hostWdata,
    input logic [accPkg::wordWidth-1:0] hostRdata
);
    import accPkg::*;

    // data layout of every test program
    localparam logic [addrWidth-1:0] addrA  = addrWidth'(8'h40);
    localparam logic [addrWidth-1:0] addrB  = addrWidth'(8'h41);
    localparam logic [addrWidth-1:0] addrR  = addrWidth'(8'h42);
    localparam logic [addrWidth-1:0] addrR2 = addrWidth'(8'h43);

    // last value the host put at each address
    logic [wordWidth-1:0] shadow [2**addrWidth];
    // second program word decides what the result should be
    logic [wordWidth-1:0] pgmWord = '0;
    logic                 pending = 1'b0;
    logic [wordWidth-1:0] expWord = '0;
    string                curName = "none";
    int                   mismatches = 0;
    int                   startMismatches = 0;
    int                   passCount = 0;
    int                   failCount = 0;

    // ALU rule straight from the operation list
    function automatic logic [wordWidth-1:0] ruleResult(
        input aluOpT op, input logic [15:0] a, input logic [15:0] b
    );
        case (op)
            aluAdd:     return a + b;
            aluSub:     return a - b;
            aluMul:     return a * b;
            aluDiv:     return (b == 16'h0000) ? 16'hffff : a / b;
            aluShl:     return {a[14:0], 1'b0};
            aluShr:     return {1'b0, a[15:1]};
            aluRol:     return {a[14:0], a[15]};
            aluRor:     return {a[0], a[15:1]};
            aluAnd:     return a & b;
            aluOr:      return a | b;
            aluXor:     return a ^ b;
            aluNor:     return ~(a | b);
            aluNand:    return ~(a & b);
            aluXnor:    return ~(a ^ b);
            aluGreater: return (a > b) ? 16'd1 : 16'd0;
            aluEqual:   return (a == b) ? 16'd1 : 16'd0;
            default:    return 16'h0000;
        endcase
    endfunction

    // what a host read of this address must return
    function automatic logic [wordWidth-1:0] expectedAt(input logic [addrWidth-1:0] addr);
        instrOpT cls;
        cls = instrOpT'(pgmWord[15:12]);
        if (addr == addrR) begin
            if (cls == opAlu) begin
                return ruleResult(aluOpT'(pgmWord[11:8]), shadow[addrA], shadow[addrB]);
            end else if (cls == opJumpZero) begin
                // marker only lands when the jump is not taken
                return (shadow[addrA] == '0) ? shadow[addrR] : shadow[addrB];
            end
            return shadow[addrA];
        end else if (addr == addrR2 && cls == opStore) begin
            return shadow[addrA];
        end
        return shadow[addr];
    endfunction

    task automatic beginTest(input string name);
        curName = name;
        startMismatches = mismatches;
    endtask

    // one line per finished test
    task automatic endTest();
        if (mismatches == startMismatches) begin
            $display("PASS %s", curName);
            passCount++;
        end else begin
            $display("FAIL %s", curName);
            failCount++;
        end
    endtask

    always @(posedge clock) begin
        // data of last cycle's read is on hostRdata now
        if (pending && hostRdata !== expWord) begin
            $display("Mismatch %s: expected 0x%h, actual 0x%h", curName, expWord, hostRdata);
            mismatches++;
        end
        pending = 1'b0;
        if (hostSel && hostWrite) begin
            shadow[hostAddr] = hostWdata;
            if (hostAddr == addrWidth'(1)) begin
                pgmWord = hostWdata;
            end
        end else if (hostSel) begin
            pending = 1'b1;
            expWord = expectedAt(hostAddr);
        end
    end

endmodule

`default_nettype wire

/* accComputer_props.sv */
`timescale 1ns/10ps
`default_nettype none

// arbitration and reset rules on the memory port
module accComputerProps #(
    parameter int addrWidth = 8
) (
    input logic                 clock,
    input logic                 rstN,
    input logic                 start,
    input logic                 coreSel,
    input logic                 coreGrant,
    input logic                 coreWrite,
    input logic [addrWidth-1:0] coreAddr,
    input logic                 busy
);

    // read back by the testbench at the end
    int assertFails = 0;

    // core request blocked by the host stays put until granted
    assert property (@(posedge clock) disable iff (!rstN)
        coreSel && !coreGrant |=> coreSel && $stable(coreWrite) && $stable(coreAddr))
    else begin
        $error("core request changed before it was granted");
        assertFails++;
    end

    // start while idle raises busy at the next edge
    assert property (@(posedge clock) disable iff (!rstN) !busy && start |=> busy)
    else begin
        $error("busy did not rise after start");
        assertFails++;
    end

    // core quiet right after a reset edge
    assert property (@(posedge clock) !rstN |=> (!busy && !coreSel))
    else begin
        $error("core busy or requesting after reset");
        assertFails++;
    end

endmodule

bind accComputer accComputerProps #(.addrWidth(addrWidth)) i_props (
    .clock(clock), .rstN(rstN), .start(start),
    .coreSel(coreBus.sel), .coreGrant(coreBus.grant),
    .coreWrite(coreBus.write), .coreAddr(coreBus.addr), .busy(busy)
);

`default_nettype wire

/* accComputerTb.sv */
`timescale 1ns/10ps
`default_nettype none

module accComputerTb;
    import accPkg::*;

    localparam int addrWidth = 8;
    // data layout shared with the checker
    localparam logic [7:0] addrA     = 8'h40;
    localparam logic [7:0] addrB     = 8'h41;
    localparam logic [7:0] addrR     = 8'h42;
    localparam logic [7:0] addrR2    = 8'h43;
    // word the host polls during contention
    localparam logic [7:0] addrNoise = 8'h50;
    // program shapes
    localparam int kAlu  = 0;
    localparam int kCopy = 1;
    localparam int kJz   = 2;
    localparam int haltLimit = 300;

    logic                 clock;
    logic                 rstN;
    logic                 start;
    logic                 hostSel;
    logic                 hostWrite;
    logic [addrWidth-1:0] hostAddr;
    logic [15:0]          hostWdata;
    logic [15:0]          hostRdata;
    logic                 busy;

    logic [31:0] lfsr;
    int          tbPass;
    int          tbFails;

    // stimulus table, one entry per test
    string       rowName[$];
    int          rowKind[$];
    aluOpT       rowOp[$];
    logic [15:0] rowA[$];
    logic [15:0] rowB[$];
    bit          rowRand[$];
    bit          rowBusy[$];

    accComputer #(.addrWidth(addrWidth)) i_dut (
        .clock(clock), .rstN(rstN), .start(start), .hostSel(hostSel),
        .hostWrite(hostWrite), .hostAddr(hostAddr), .hostWdata(hostWdata),
        .hostRdata(hostRdata), .busy(busy)
    );

    accChecker #(.addrWidth(addrWidth)) i_checker (
        .clock(clock), .hostSel(i_dut.hostSel), .hostWrite(i_dut.hostWrite),
        .hostAddr(i_dut.hostAddr), .hostWdata(i_dut.hostWdata),
        .hostRdata(i_dut.hostRdata)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit of the word
    task automatic drawWord(output logic [15:0] w);
        w = '0;
        for (int k = 0; k < 16; k++) begin
            lfsr = lfsrStep(lfsr);
            w = {w[14:0], lfsr[0]};
        end
    endtask

    function automatic logic [15:0] encode(input instrOpT op, input aluOpT alu,
                                           input logic [7:0] addr);
        return {op, alu, addr};
    endfunction

    task automatic addRow(input string name, input int kind, input aluOpT op,
                          input logic [15:0] a, input logic [15:0] b,
                          input bit rnd, input bit contend);
        rowName.push_back(name);
        rowKind.push_back(kind);
        rowOp.push_back(op);
        rowA.push_back(a);
        rowB.push_back(b);
        rowRand.push_back(rnd);
        rowBusy.push_back(contend);
    endtask

    task automatic buildTable();
        addRow("add", kAlu, aluAdd, 16'h1234, 16'h0f0f, 1'b0, 1'b0);
        addRow("sub", kAlu, aluSub, 16'h1000, 16'h0001, 1'b0, 1'b0);
        addRow("mul", kAlu, aluMul, 16'h0123, 16'h0045, 1'b0, 1'b0);
        addRow("div", kAlu, aluDiv, 16'h9000, 16'h0007, 1'b0, 1'b0);
        addRow("divZero", kAlu, aluDiv, 16'h4321, 16'h0000, 1'b0, 1'b0);
        addRow("shl", kAlu, aluShl, 16'h8001, 16'h0000, 1'b0, 1'b0);
        addRow("shr", kAlu, aluShr, 16'h8001, 16'h0000, 1'b0, 1'b0);
        addRow("rol", kAlu, aluRol, 16'h8001, 16'h0000, 1'b0, 1'b0);
        addRow("ror", kAlu, aluRor, 16'h8001, 16'h0000, 1'b0, 1'b0);
        addRow("and", kAlu, aluAnd, 16'hf0f0, 16'hff00, 1'b0, 1'b0);
        addRow("or", kAlu, aluOr, 16'hf0f0, 16'hff00, 1'b0, 1'b0);
        addRow("xor", kAlu, aluXor, 16'hf0f0, 16'hff00, 1'b0, 1'b0);
        addRow("nor", kAlu, aluNor, 16'hf0f0, 16'hff00, 1'b0, 1'b0);
        addRow("nand", kAlu, aluNand, 16'hf0f0, 16'hff00, 1'b0, 1'b0);
        addRow("xnor", kAlu, aluXnor, 16'hf0f0, 16'hff00, 1'b0, 1'b0);
        addRow("greater", kAlu, aluGreater, 16'h0005, 16'h0003, 1'b0, 1'b0);
        addRow("notGreater", kAlu, aluGreater, 16'h0003, 16'h0005, 1'b0, 1'b0);
        addRow("equal", kAlu, aluEqual, 16'hbeef, 16'hbeef, 1'b0, 1'b0);
        addRow("randAdd", kAlu, aluAdd, 16'h0000, 16'h0000, 1'b1, 1'b0);
        addRow("randSub", kAlu, aluSub, 16'h0000, 16'h0000, 1'b1, 1'b0);
        addRow("randMul", kAlu, aluMul, 16'h0000, 16'h0000, 1'b1, 1'b0);
        addRow("randXor", kAlu, aluXor, 16'h0000, 16'h0000, 1'b1, 1'b0);
        addRow("copy", kCopy, aluAdd, 16'hc3a5, 16'h0000, 1'b0, 1'b0);
        addRow("jzTaken", kJz, aluAdd, 16'h0000, 16'h7777, 1'b0, 1'b0);
        addRow("jzNotTaken", kJz, aluAdd, 16'h0042, 16'h7777, 1'b0, 1'b0);
        addRow("contention", kAlu, aluMul, 16'h0101, 16'h0202, 1'b0, 1'b1);
    endtask

    // inputs move 1 ns after the edge
    task automatic stepCycle();
        @(posedge clock);
        #1;
    endtask

    // host is granted in the cycle it selects
    task automatic hostWriteWord(input logic [7:0] addr, input logic [15:0] data);
        hostSel   = 1'b1;
        hostWrite = 1'b1;
        hostAddr  = addr;
        hostWdata = data;
        stepCycle();
        hostSel   = 1'b0;
        hostWrite = 1'b0;
    endtask

    // read data shows up a cycle later for the checker
    task automatic hostRead(input logic [7:0] addr);
        hostSel   = 1'b1;
        hostWrite = 1'b0;
        hostAddr  = addr;
        stepCycle();
        hostSel   = 1'b0;
    endtask

    task automatic abortRun(input string why);
        $display("Timeout: %s", why);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic loadProgram(input int kind, input aluOpT op);
        hostWriteWord(8'h00, encode(opLoad, aluAdd, addrA));
        case (kind)
            kCopy: begin
                hostWriteWord(8'h01, encode(opStore, aluAdd, addrR));
                hostWriteWord(8'h02, encode(opStore, aluAdd, addrR2));
                hostWriteWord(8'h03, encode(opHalt, aluAdd, 8'h00));
            end
            kJz: begin
                // zero skips the marker store
                hostWriteWord(8'h01, encode(opJumpZero, aluAdd, 8'h04));
                hostWriteWord(8'h02, encode(opLoad, aluAdd, addrB));
                hostWriteWord(8'h03, encode(opStore, aluAdd, addrR));
                hostWriteWord(8'h04, encode(opHalt, aluAdd, 8'h00));
            end
            default: begin
                hostWriteWord(8'h01, encode(opAlu, op, addrB));
                hostWriteWord(8'h02, encode(opStore, aluAdd, addrR));
                hostWriteWord(8'h03, encode(opHalt, aluAdd, 8'h00));
            end
        endcase
    endtask

    task automatic checkResetIdle();
        bit ok;
        ok = 1'b1;
        repeat (3) begin
            if (busy !== 1'b0) ok = 1'b0;
            stepCycle();
        end
        if (ok) begin
            $display("PASS resetIdle");
            tbPass++;
        end else begin
            $display("FAIL resetIdle: busy went high before any start");
            tbFails++;
        end
    endtask

    task automatic runRow(input int i);
        logic [15:0] a;
        logic [15:0] b;
        int          cycles;
        a = rowA[i];
        b = rowB[i];
        if (rowRand[i]) begin
            drawWord(a);
            drawWord(b);
        end
        i_checker.beginTest(rowName[i]);
        loadProgram(rowKind[i], rowOp[i]);
        hostWriteWord(addrA, a);
        hostWriteWord(addrB, b);
        // cleared results make a skipped store visible
        hostWriteWord(addrR, 16'h0000);
        hostWriteWord(addrR2, 16'h0000);
        hostWriteWord(addrNoise, 16'h5a00 ^ 16'(i));
        start = 1'b1;
        stepCycle();
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("busy did not rise after start in %s", rowName[i]);
            tbFails++;
        end
        // every other cycle left free so the core can move
        cycles = 0;
        while (busy === 1'b1 && cycles < haltLimit) begin
            if (rowBusy[i] && cycles % 2 == 0) hostRead(addrNoise);
            else stepCycle();
            cycles++;
        end
        if (busy === 1'b1) begin
            abortRun($sformatf("%s did not halt in %0d cycles", rowName[i], haltLimit));
        end else begin
            hostRead(addrR);
            if (rowKind[i] == kCopy) hostRead(addrR2);
            stepCycle();
            i_checker.endTest();
        end
    endtask

    initial begin
        int passed;
        int failed;
        int other;
        rstN      = 1'b0;
        start     = 1'b0;
        hostSel   = 1'b0;
        hostWrite = 1'b0;
        hostAddr  = '0;
        hostWdata = '0;
        lfsr      = 32'he505_9a3f;
        tbPass    = 0;
        tbFails   = 0;
        buildTable();
        repeat (5) @(posedge clock);
        #1;
        rstN = 1'b1;
        checkResetIdle();
        for (int i = 0; i < rowName.size(); i++) begin
            runRow(i);
        end
        stepCycle();
        passed = i_checker.passCount + tbPass;
        failed = i_checker.failCount;
        other  = tbFails + i_dut.i_props.assertFails;
        $display("%0d passed, %0d failed, %0d other errors", passed, failed, other);
        if (failed == 0 && other == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
accPkg.sv
memBus.sv
mainMemory.sv
aluUnit.sv
memArbiter.sv
accCore.sv
accComputer.sv
accChecker.sv
accComputer_props.sv
accComputerTb.sv

/* Makefile */
TOP = accComputerTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -o simv
	./obj_dir/simv +verilator+error+limit+100 2>&1 | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then \
		echo "run failed, see sim.log"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" sim.log; then \
		echo "run ended without a result, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
